// ==== Bender.yml ====
package:
  name: eeprom_wr

export_include_dirs:
  - .

sources:
  - eeprom_cmd_pkg.sv
  - bus_op_pkg.sv
  - eeprom_sequencer.sv
  - bus_op_fifo.sv
  - i2c_bit_engine.sv
  - eeprom_wr.sv
  - target: test
    files:
      - eeprom_slave_model.sv
      - eeprom_wr_tb.sv

// ==== bus_op_fifo.sv ====
`include "eeprom_defs.svh"

module bus_op_fifo
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                op_push,
    input  bus_op_pkg::bus_op_t op_word,
    input  logic                op_pop,
    output bus_op_pkg::bus_op_t op_head,
    output logic                op_full,
    output logic                op_empty
);

    localparam int DEPTH = `OP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    bus_op_pkg::bus_op_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                push_ok;
    logic                pop_ok;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ok  = op_push && !op_full;
    assign pop_ok   = op_pop && !op_empty;
    assign op_full  = (count == (PTR_W + 1)'(DEPTH));
    assign op_empty = (count == '0);
    assign op_head  = mem[rd_ptr]; // show-ahead

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop_ok)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push_ok)
            mem[wr_ptr] <= op_word;
    end

    // a push refused by a full buffer stays on offer with the same word
    held_push_keeps_word: assert property (
        @(posedge CLK) disable iff (RESET)
        (op_push && op_full) |=> (op_push && $stable(op_word))
    );

    no_pop_while_empty: assert property (
        @(posedge CLK) disable iff (RESET)
        op_pop |-> !op_empty
    );

endmodule

// ==== bus_op_pkg.sv ====
package bus_op_pkg;

    // op_start gives a repeated start when the bus is already taken
    typedef enum logic [1:0]
    {
        op_start,
        op_write,
        op_read,
        op_stop
    } op_code_t;

    // {op_code_t, payload}, payload only meaningful for op_write
    typedef logic [9:0] bus_op_t;

    typedef enum logic [2:0]
    {
        idle,
        fetch,
        start,
        shift,
        ack_slot,
        stop
    } bit_state_t;

endpackage

// ==== eeprom_cmd_pkg.sv ====
package eeprom_cmd_pkg;

    // byte address inside the 2 KB array, bits 10:8 select the block
    typedef logic [10:0] addr_t;

    typedef logic [7:0] data_t;

    // host command sequencer
    typedef enum logic [1:0]
    {
        idle,
        issue,
        wait_done
    } seq_state_t;

endpackage

// ==== eeprom_defs.svh ====
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// clk cycles per quarter of an scl period, kept short for simulation
`define SCL_QUARTER 2

// bus operations buffered between sequencer and bit engine
`define OP_FIFO_DEPTH 4

// 24Cxx device type code, upper nibble of the control byte
`define DEV_CODE 4'b1010

`endif

// ==== eeprom_sequencer.sv ====
`include "eeprom_defs.svh"

module eeprom_sequencer
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_cmd_pkg::addr_t addr,
    input  eeprom_cmd_pkg::data_t wdata,
    input  logic                  op_full,
    input  logic                  done,
    output logic                  busy,
    output logic                  op_push,
    output bus_op_pkg::bus_op_t   op_word
);

    eeprom_cmd_pkg::seq_state_t state;
    eeprom_cmd_pkg::addr_t      addr_q;
    eeprom_cmd_pkg::data_t      wdata_q;
    eeprom_cmd_pkg::data_t      payload;
    bus_op_pkg::op_code_t       code;
    logic                       is_read;
    logic [2:0]                 op_idx;
    logic                       last_op;

    // write list is start, ctrl_w, addr_lo, data, stop
    // read list is start, ctrl_w, addr_lo, start, ctrl_r, read, stop
    always_comb
    begin
        code    = bus_op_pkg::op_stop;
        payload = '0;
        case (op_idx)
            3'd0: code = bus_op_pkg::op_start;
            3'd1:
            begin
                code    = bus_op_pkg::op_write;
                payload = {`DEV_CODE, addr_q[10:8], 1'b0};
            end
            3'd2:
            begin
                code    = bus_op_pkg::op_write;
                payload = addr_q[7:0];
            end
            3'd3:
            begin
                code    = is_read ? bus_op_pkg::op_start : bus_op_pkg::op_write;
                payload = wdata_q;
            end
            3'd4:
            begin
                code    = is_read ? bus_op_pkg::op_write : bus_op_pkg::op_stop;
                payload = {`DEV_CODE, addr_q[10:8], 1'b1}; // read control byte
            end
            3'd5: code = bus_op_pkg::op_read;
            default: code = bus_op_pkg::op_stop;
        endcase
    end

    assign last_op = is_read ? (op_idx == 3'd6) : (op_idx == 3'd4);
    assign op_word = {code, payload};
    assign op_push = (state == eeprom_cmd_pkg::issue);
    assign busy    = (state != eeprom_cmd_pkg::idle);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= eeprom_cmd_pkg::idle;
            op_idx  <= '0;
            is_read <= 1'b0;
        end
        else
        begin
            case (state)
                eeprom_cmd_pkg::idle:
                if (wr || rd)
                begin
                    is_read <= !wr; // wr has priority
                    op_idx  <= '0;
                    state   <= eeprom_cmd_pkg::issue;
                end
                eeprom_cmd_pkg::issue:
                if (!op_full)
                begin
                    op_idx <= op_idx + 3'd1;
                    if (last_op)
                        state <= eeprom_cmd_pkg::wait_done;
                end
                eeprom_cmd_pkg::wait_done:
                if (done)
                    state <= eeprom_cmd_pkg::idle;
                default: state <= eeprom_cmd_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_cmd_pkg::idle && (wr || rd))
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    // the engine signals done only on a stop
    last_push_is_stop: assert property (
        @(posedge CLK) disable iff (RESET)
        (op_push && last_op) |-> (code == bus_op_pkg::op_stop)
    );

    // the engine may only finish a stop that this sequencer queued
    done_only_when_waiting: assert property (
        @(posedge CLK) disable iff (RESET)
        done |-> (state == eeprom_cmd_pkg::wait_done)
    );

endmodule

// ==== eeprom_slave_model.sv ====
`include "eeprom_defs.svh"

module eeprom_slave_model
(
    input  logic scl,
    inout  wire  sda,
    input  logic no_ack
);

    typedef enum logic [2:0]
    {
        m_idle,
        m_ctrl,
        m_addr,
        m_data,
        m_send
    } mode_t;

    logic [7:0]  mem [2048];
    mode_t       mode;
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [10:0] ptr;
    logic [3:0]  bit_idx;
    logic        in_ack;
    logic        drive_low;
    logic        scl_prev;
    logic        sda_prev;

    assign sda = drive_low ? 1'b0 : 1'bz;

    // a received byte is complete, decide what it means and whether to ack
    task automatic take_byte();
        case (mode)
            m_ctrl:
            if (sh[7:4] == `DEV_CODE && !no_ack)
            begin
                ptr[10:8] = sh[3:1];
                drive_low = 1'b1;
                if (sh[0])
                begin
                    mode = m_send;
                    tx   = mem[ptr];
                end
                else
                    mode = m_addr;
            end
            else
                mode = m_idle; // not addressed, stay off the bus
            m_addr:
            begin
                ptr[7:0]  = sh;
                mode      = m_data;
                drive_low = 1'b1;
            end
            m_data:
            begin
                mem[ptr]  = sh;
                drive_low = 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic scl_fall();
        if (in_ack)
        begin
            in_ack    = 1'b0;
            bit_idx   = '0;
            drive_low = (mode == m_send) && !tx[7];
        end
        else if (bit_idx == 4'd8)
        begin
            in_ack    = 1'b1;
            drive_low = 1'b0; // master owns the ack slot of a sent byte
            if (mode != m_send)
                take_byte();
        end
        else if (mode == m_send && bit_idx != 4'd0)
            drive_low = !tx[7 - bit_idx];
    endtask

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff; // erased
        mode      = m_idle;
        drive_low = 1'b0;
        in_ack    = 1'b0;
        bit_idx   = '0;
        scl_prev  = 1'b1;
        sda_prev  = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl && scl_prev && sda_prev && !sda)
            begin
                mode      = m_ctrl; // start or repeated start
                bit_idx   = '0;
                in_ack    = 1'b0;
                drive_low = 1'b0;
            end
            else if (scl && scl_prev && !sda_prev && sda)
            begin
                mode      = m_idle; // stop
                drive_low = 1'b0;
            end
            else if (scl && !scl_prev && mode != m_idle)
            begin
                if (!in_ack)
                begin
                    sh      = {sh[6:0], sda};
                    bit_idx = bit_idx + 4'd1;
                end
                else if (mode == m_send && sda)
                    mode = m_idle; // master nack ends the read
            end
            else if (!scl && scl_prev && mode != m_idle)
                scl_fall();
            scl_prev = scl;
            sda_prev = sda;
        end
    end

endmodule

// ==== eeprom_wr.f ====
+incdir+.
eeprom_cmd_pkg.sv
bus_op_pkg.sv
eeprom_sequencer.sv
bus_op_fifo.sv
i2c_bit_engine.sv
eeprom_wr.sv
eeprom_slave_model.sv
eeprom_wr_tb.sv

// ==== eeprom_wr.sv ====
module eeprom_wr
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_cmd_pkg::addr_t addr,
    input  eeprom_cmd_pkg::data_t wdata,
    output logic                  busy,
    output logic                  ack,
    output logic                  nack,
    output eeprom_cmd_pkg::data_t rdata,
    output logic                  scl,
    inout  wire                   sda
);

    bus_op_pkg::bus_op_t op_word;
    bus_op_pkg::bus_op_t op_head;
    logic                op_push;
    logic                op_pop;
    logic                op_full;
    logic                op_empty;
    logic                sda_drive_low;
    logic                done;

    // open drain, pull-up is external
    assign sda = sda_drive_low ? 1'b0 : 1'bz;
    assign ack = done;

    eeprom_sequencer u_seq
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .op_full (op_full),
        .done    (done),
        .busy    (busy),
        .op_push (op_push),
        .op_word (op_word)
    );

    bus_op_fifo u_fifo
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_push  (op_push),
        .op_word  (op_word),
        .op_pop   (op_pop),
        .op_head  (op_head),
        .op_full  (op_full),
        .op_empty (op_empty)
    );

    i2c_bit_engine u_engine
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_head       (op_head),
        .op_empty      (op_empty),
        .sda_in        (sda),
        .op_pop        (op_pop),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .rdata         (rdata),
        .nack          (nack),
        .done          (done)
    );

endmodule

// ==== eeprom_wr_tb.sv ====
module eeprom_wr_tb;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    eeprom_cmd_pkg::addr_t addr;
    eeprom_cmd_pkg::data_t wdata;
    logic                  busy;
    logic                  ack;
    logic                  nack;
    eeprom_cmd_pkg::data_t rdata;
    logic                  scl;
    wire                   sda;
    logic                  no_ack;
    int                    errors;
    int                    checks;
    logic                  timed_out;

    pullup (sda);

    eeprom_wr dut
    (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .ack   (ack),
        .nack  (nack),
        .rdata (rdata),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_slave_model eeprom
    (
        .scl    (scl),
        .sda    (sda),
        .no_ack (no_ack)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #5 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // strobe on a falling edge, then follow busy until the single ack
    task automatic run_command(input string name, input logic is_read,
                               input eeprom_cmd_pkg::addr_t a,
                               input eeprom_cmd_pkg::data_t d,
                               input logic exp_nack, input logic busy_strobe);
        int                    cycles;
        logic                  seen;
        eeprom_cmd_pkg::data_t got_data;
        logic                  got_nack;
        cycles = 0;
        seen   = 1'b0;
        check_value({name, " busy before strobe"}, 0, busy);
        wr    = !is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        rd = 1'b0;
        while (!seen && cycles < 2000)
        begin
            wr = busy_strobe && (cycles == 8); // second strobe lands while busy
            if (wr)
            begin
                addr  = a + 11'd1;
                wdata = ~d;
            end
            check_value({name, " busy"}, 1, busy);
            if (ack)
            begin
                seen     = 1'b1;
                got_data = rdata;
                got_nack = nack;
            end
            else
            begin
                @(negedge CLK);
                cycles++;
            end
        end
        wr = 1'b0;
        if (!seen)
        begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %s saw no ack within 2000 cycles", name);
        end
        else
        begin
            if (is_read)
                check_value({name, " rdata"}, d, got_data);
            check_value({name, " nack"}, exp_nack, got_nack);
            repeat (24)
            begin
                @(negedge CLK);
                check_value({name, " ack after end"}, 0, ack);
                check_value({name, " busy after end"}, 0, busy);
            end
        end
    endtask

    initial
    begin
        int          fd;
        int          fields;
        int          cmd_no;
        int          ch;
        logic [7:0]  op;
        logic [31:0] a_val;
        logic [31:0] d_val;
        logic [31:0] n_val;
        logic        hold_ack;
        string       name;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        no_ack    = 1'b0;
        RESET     = 1'b1;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        hold_ack  = 1'b0;
        cmd_no    = 0;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        repeat (4) @(negedge CLK);
        check_value("idle scl", 1, scl);
        check_value("idle sda", 1, sda);
        check_value("idle busy", 0, busy);
        check_value("idle nack", 0, nack);
        fd = $fopen("eeprom_wr_trace.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open eeprom_wr_trace.txt");
        end
        else
        begin
            while (!timed_out && $fscanf(fd, " %c", op) == 1)
            begin
                if (op == "#")
                begin
                    ch = 0;
                    while (ch != "\n" && ch != -1)
                        ch = $fgetc(fd);
                end
                else
                begin
                    fields = $fscanf(fd, " %h %h %h", a_val, d_val, n_val);
                    cmd_no++;
                    name = $sformatf("cmd %0d %c %h", cmd_no, op, a_val[10:0]);
                    if (fields != 3)
                    begin
                        errors++;
                        $display("trace entry %0d is missing fields", cmd_no);
                    end
                    else if (op == "N")
                        hold_ack = 1'b1; // applies to the next command
                    else if (op == "W" || op == "R" || op == "B")
                    begin
                        no_ack = hold_ack;
                        run_command(name, op == "R", a_val[10:0], d_val[7:0],
                                    n_val[0], op == "B");
                        no_ack   = 1'b0;
                        hold_ack = 1'b0;
                    end
                    else
                    begin
                        errors++;
                        $display("unknown command letter in trace entry %0d", cmd_no);
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== eeprom_wr_trace.txt ====
# op addr data nack, hex; W write, R read and compare data, N no slave ack on next command
# B write, plus a write strobe to addr+1 with inverted data while busy
W 000 3c 0
R 000 3c 0
W 1a5 a7 0
W 2ff 01 0
W 7fe c3 0
R 1a5 a7 0
R 2ff 01 0
R 7fe c3 0
R 455 ff 0
W 1a5 5e 0
R 1a5 5e 0
N 000 00 0
W 2ff 99 1
R 2ff 01 0
B 3c0 66 0
R 3c1 ff 0
R 3c0 66 0

// ==== i2c_bit_engine.sv ====
`include "eeprom_defs.svh"

module i2c_bit_engine
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  bus_op_pkg::bus_op_t   op_head,
    input  logic                  op_empty,
    input  logic                  sda_in,
    output logic                  op_pop,
    output logic                  scl,
    output logic                  sda_drive_low,
    output eeprom_cmd_pkg::data_t rdata,
    output logic                  nack,
    output logic                  done
);

    localparam int QW = $clog2(`SCL_QUARTER + 1);

    bus_op_pkg::bit_state_t state;
    bus_op_pkg::op_code_t   op_q;
    bus_op_pkg::op_code_t   head_code;
    eeprom_cmd_pkg::data_t  shreg;
    logic [QW-1:0]          q_cnt;
    logic [1:0]             phase;   // quarter within the bit
    logic [2:0]             bit_cnt;
    logic                   bus_active; // start sent, no stop yet
    logic                   active;
    logic                   tick;
    logic                   sample;
    logic                   bit_end;
    logic                   scl_lvl;
    logic                   sda_lvl;

    assign head_code = bus_op_pkg::op_code_t'(op_head[9:8]);
    assign op_pop    = (state == bus_op_pkg::fetch) && !op_empty;
    assign active    = state inside {bus_op_pkg::start, bus_op_pkg::shift,
                                     bus_op_pkg::ack_slot, bus_op_pkg::stop};
    assign tick      = active && (q_cnt == QW'(`SCL_QUARTER - 1));
    assign sample    = tick && (phase == 2'd2); // end of scl high time
    assign bit_end   = tick && (phase == 2'd3);

    // bus levels for the current quarter
    always_comb
    begin
        scl_lvl = (phase == 2'd1) || (phase == 2'd2);
        sda_lvl = 1'b0;
        case (state)
            bus_op_pkg::start: sda_lvl = phase[1]; // falls while scl high
            bus_op_pkg::shift: sda_lvl = (op_q == bus_op_pkg::op_write) && !shreg[7];
            bus_op_pkg::stop:
            begin
                scl_lvl = (phase != 2'd0);
                sda_lvl = !phase[1]; // rises while scl high
            end
            default: ; // ack slot and nack leave sda released
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= bus_op_pkg::idle;
            q_cnt         <= '0;
            phase         <= '0;
            bit_cnt       <= '0;
            bus_active    <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            nack          <= 1'b0;
            done          <= 1'b0;
        end
        else
        begin
            done  <= bit_end && (state == bus_op_pkg::stop);
            q_cnt <= (tick || !active) ? '0 : q_cnt + 1'b1;
            if (tick)
                phase <= phase + 2'd1;
            if (active)
            begin
                scl           <= scl_lvl;
                sda_drive_low <= sda_lvl;
            end
            case (state)
                bus_op_pkg::idle:
                if (!op_empty)
                    state <= bus_op_pkg::fetch;
                bus_op_pkg::fetch:
                if (!op_empty)
                begin
                    case (head_code)
                        bus_op_pkg::op_start:
                        begin
                            if (!bus_active)
                                nack <= 1'b0; // new transaction
                            state <= bus_op_pkg::start;
                        end
                        bus_op_pkg::op_stop: state <= bus_op_pkg::stop;
                        default: state <= bus_op_pkg::shift;
                    endcase
                end
                bus_op_pkg::start:
                if (bit_end)
                begin
                    bus_active <= 1'b1;
                    state      <= bus_op_pkg::fetch;
                end
                bus_op_pkg::shift:
                if (bit_end)
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state <= bus_op_pkg::ack_slot;
                end
                bus_op_pkg::ack_slot:
                begin
                    if (sample && op_q == bus_op_pkg::op_write && sda_in)
                        nack <= 1'b1; // slave did not pull sda low
                    if (bit_end)
                        state <= bus_op_pkg::fetch;
                end
                bus_op_pkg::stop:
                if (bit_end)
                begin
                    bus_active <= 1'b0;
                    state      <= bus_op_pkg::idle;
                end
                default: state <= bus_op_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_pop)
        begin
            op_q  <= head_code;
            shreg <= op_head[7:0];
        end
        else if (state == bus_op_pkg::shift)
        begin
            if (op_q == bus_op_pkg::op_read && sample)
                shreg <= {shreg[6:0], sda_in};
            else if (op_q == bus_op_pkg::op_write && bit_end)
                shreg <= {shreg[6:0], 1'b0}; // msb first
        end
        if (state == bus_op_pkg::shift && op_q == bus_op_pkg::op_read
            && sample && bit_cnt == 3'd7)
            rdata <= {shreg[6:0], sda_in};
    end

    sda_stable_while_scl_high: assert property (
        @(posedge CLK) disable iff (RESET)
        ($changed(sda_drive_low) && !(state inside {bus_op_pkg::start, bus_op_pkg::stop}))
            |-> !scl
    );

endmodule
